/* rtl/fp16_mul_pkg.sv */
// Types and constants for the three-stage binary16 multiplier
// All widths follow from the IEEE 754 half-precision format
// Rounding mode values match the RISC-V frm encoding; 5 to 7 are not valid
package fp16_mul_pkg;

  // --------------------------------------------------
  // Format constants
  // --------------------------------------------------
  localparam int unsigned EXP_BITS       = 5;
  localparam int unsigned MAN_BITS       = 10;
  localparam int unsigned BIAS           = 15;
  // Mantissa with the hidden bit
  localparam int unsigned PRECISION_BITS = MAN_BITS + 1;
  localparam int unsigned PRODUCT_BITS   = 2 * PRECISION_BITS;
  // Signed internal exponent, holds sums of two exponents and subnormal offsets
  localparam int unsigned EXP_WIDTH      = 7;
  // Leading-zero count over the product, up to PRODUCT_BITS
  localparam int unsigned LZC_WIDTH      = 5;

  // --------------------------------------------------
  // Operand, class and flag types
  // --------------------------------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp16_t;

  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // Same bit order as the RISC-V fflags field
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  // Bypass result for NaN and infinity operands
  typedef struct packed {
    logic    is_special;
    fp16_t   result;
    status_t status;
  } special_t;

  // --------------------------------------------------
  // Pipeline payloads
  // --------------------------------------------------
  typedef struct packed {
    logic                        sign;
    logic signed [EXP_WIDTH-1:0] exponent;
    logic [PRODUCT_BITS-1:0]     product;
    round_mode_e                 rnd_mode;
    special_t                    special;
  } prod_stage_t;

  typedef struct packed {
    logic                        sign;
    logic signed [EXP_WIDTH-1:0] exponent;
    // Hidden bit, fraction, then the round bit in bit 0
    logic [PRECISION_BITS:0]     mantissa;
    // First bit below the round bit, kept apart for the tininess check
    logic                        guard;
    logic                        sticky;
    round_mode_e                 rnd_mode;
    special_t                    special;
  } norm_stage_t;

endpackage

/* rtl/fp_classifier.sv */
// Combinational class decode of both multiplier operands
// A NaN with the top mantissa bit clear counts as signalling
module fp_classifier import fp16_mul_pkg::*; (
  input  fp16_t    operand_a_i,
  input  fp16_t    operand_b_i,
  output fp_info_t info_a_o,
  output fp_info_t info_b_o
);

  // Decode of one operand, shared by both ports
  function automatic fp_info_t classify(fp16_t value);
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    fp_info_t info;
    exp_zero = (value.exponent == '0);
    exp_ones = (value.exponent == '1);
    man_zero = (value.mantissa == '0);
    info.is_zero      = exp_zero & man_zero;
    info.is_subnormal = exp_zero & ~man_zero;
    info.is_normal    = ~exp_zero & ~exp_ones;
    info.is_inf       = exp_ones & man_zero;
    info.is_nan       = exp_ones & ~man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = exp_ones & ~man_zero & ~value.mantissa[MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = classify(operand_a_i);
  assign info_b_o = classify(operand_b_i);

endmodule

/* rtl/mul_special_cases.sv */
// Bypass result for operands the regular datapath cannot handle
// Zeros and finite operands go through the regular path
// NaN results are always the canonical quiet NaN 0x7E00
module mul_special_cases import fp16_mul_pkg::*; (
  input  fp16_t    operand_a_i,
  input  fp16_t    operand_b_i,
  input  fp_info_t info_a_i,
  input  fp_info_t info_b_i,
  output special_t special_o
);

  logic  inf_times_zero;
  logic  any_nan;
  logic  any_snan;
  logic  any_inf;
  fp16_t quiet_nan;

  assign inf_times_zero = (info_a_i.is_inf & info_b_i.is_zero) |
                          (info_a_i.is_zero & info_b_i.is_inf);
  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;
  assign any_inf  = info_a_i.is_inf | info_b_i.is_inf;

  // Positive sign, all-ones exponent, only the quiet bit set
  assign quiet_nan = '{sign: 1'b0, exponent: '1, mantissa: MAN_BITS'(1) << (MAN_BITS - 1)};

  // --------------------------------------------------
  // Priority: inf * 0, then NaN, then infinity
  // --------------------------------------------------
  always_comb begin : select_special
    special_o.is_special = 1'b0;
    special_o.result     = quiet_nan;
    special_o.status     = '0;
    if (inf_times_zero) begin
      // Invalid even if the other operand looks harmless
      special_o.is_special = 1'b1;
      special_o.status.nv  = 1'b1;
    end else if (any_nan) begin
      special_o.is_special = 1'b1;
      special_o.status.nv  = any_snan;
    end else if (any_inf) begin
      // Signed infinity, exact, no flags
      special_o.is_special = 1'b1;
      special_o.result     = '{
        sign:     operand_a_i.sign ^ operand_b_i.sign,
        exponent: '1,
        mantissa: '0
      };
    end
  end

endmodule

/* rtl/mantissa_multiplier.sv */
// Pipeline stage 1 of the multiplier
// Exponent stays biased; a subnormal operand counts as encoded exponent 1
// A zero product gets the smallest reachable exponent, 2 - BIAS
// Only the valid bit is reset
module mantissa_multiplier import fp16_mul_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        valid_i,
  input  fp16_t       operand_a_i,
  input  fp16_t       operand_b_i,
  input  fp_info_t    info_a_i,
  input  fp_info_t    info_b_i,
  input  round_mode_e rnd_mode_i,
  input  special_t    special_i,
  output logic        valid_o,
  output prod_stage_t stage_o
);

  logic [PRECISION_BITS-1:0]   mantissa_a;
  logic [PRECISION_BITS-1:0]   mantissa_b;
  logic signed [EXP_WIDTH-1:0] exponent_a;
  logic signed [EXP_WIDTH-1:0] exponent_b;
  prod_stage_t                 stage_d;
  logic                        valid_q;
  prod_stage_t                 stage_q;

  // Hidden bit only for normal operands
  assign mantissa_a = {info_a_i.is_normal, operand_a_i.mantissa};
  assign mantissa_b = {info_b_i.is_normal, operand_b_i.mantissa};

  // Subnormals share the exponent of the smallest normal
  assign exponent_a = EXP_WIDTH'(operand_a_i.exponent) + EXP_WIDTH'(info_a_i.is_subnormal);
  assign exponent_b = EXP_WIDTH'(operand_b_i.exponent) + EXP_WIDTH'(info_b_i.is_subnormal);

  always_comb begin : form_product
    stage_d.sign    = operand_a_i.sign ^ operand_b_i.sign;
    // 11 x 11 bits, binary point below bit 20
    stage_d.product = mantissa_a * mantissa_b;
    if (info_a_i.is_zero || info_b_i.is_zero) begin
      stage_d.exponent = EXP_WIDTH'(2) - EXP_WIDTH'(BIAS);
    end else begin
      stage_d.exponent = exponent_a + exponent_b - EXP_WIDTH'(BIAS);
    end
    stage_d.rnd_mode = rnd_mode_i;
    stage_d.special  = special_i;
  end

  // --------------------------------------------------
  // Stage 1 registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload loads every cycle
  always_ff @(posedge clk_i) begin
    stage_q <= stage_d;
  end

  assign valid_o = valid_q;
  assign stage_o = stage_q;

endmodule

/* rtl/mul_normalizer.sv */
// Pipeline stage 2 of the multiplier
// Result exponent is never below 0; subnormal results carry exponent 0
// The right shift is at most 13 places, so no product bit falls off the padding
// Only the valid bit is reset
module mul_normalizer import fp16_mul_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        valid_i,
  input  prod_stage_t stage_i,
  output logic        valid_o,
  output norm_stage_t stage_o
);

  // Room below the product for bits moved out by a right shift
  localparam int unsigned PAD_BITS = 16;
  localparam int unsigned EXT_BITS = PRODUCT_BITS + PAD_BITS;

  logic [LZC_WIDTH-1:0]        lead_zeros;
  logic signed [EXP_WIDTH-1:0] exp_prod;
  logic signed [EXP_WIDTH-1:0] exp_norm;
  logic signed [EXP_WIDTH-1:0] exp_final;
  logic                        prod_zero;
  logic                        shift_right;
  logic [LZC_WIDTH-1:0]        shamt;
  logic [EXT_BITS-1:0]         extended;
  logic [EXT_BITS-1:0]         shifted;
  norm_stage_t                 stage_d;
  logic                        valid_q;
  norm_stage_t                 stage_q;

  assign exp_prod  = stage_i.exponent;
  assign prod_zero = (stage_i.product == '0);

  // --------------------------------------------------
  // Leading-zero count
  // --------------------------------------------------
  // Highest set bit wins, all zeros gives PRODUCT_BITS
  always_comb begin : count_zeros
    lead_zeros = LZC_WIDTH'(PRODUCT_BITS);
    for (int i = 0; i < PRODUCT_BITS; i++) begin
      if (stage_i.product[i]) begin
        lead_zeros = LZC_WIDTH'(PRODUCT_BITS - 1 - i);
      end
    end
  end

  // Product bit 21 weighs 2^1, hence the +1
  assign exp_norm = exp_prod + 1 - $signed(EXP_WIDTH'(lead_zeros));

  // --------------------------------------------------
  // Shift selection
  // --------------------------------------------------
  always_comb begin : shift_select
    if (!prod_zero && (exp_norm > 0)) begin
      // Normal result, remove all leading zeros
      shift_right = 1'b0;
      shamt       = lead_zeros;
      exp_final   = exp_norm;
    end else if (exp_prod >= 0) begin
      // Subnormal, cap the shift at the minimum exponent
      shift_right = 1'b0;
      shamt       = exp_prod[LZC_WIDTH-1:0];
      exp_final   = '0;
    end else begin
      // Already below the minimum exponent
      shift_right = 1'b1;
      shamt       = LZC_WIDTH'(-exp_prod);
      exp_final   = '0;
    end
  end

  assign extended = {stage_i.product, {PAD_BITS{1'b0}}};
  assign shifted  = shift_right ? (extended >> shamt) : (extended << shamt);

  always_comb begin : pack_stage
    stage_d.sign     = stage_i.sign;
    stage_d.exponent = exp_final;
    // Hidden bit, 10 fraction bits and the round bit
    stage_d.mantissa = shifted[EXT_BITS-1 -: PRECISION_BITS+1];
    stage_d.guard    = shifted[EXT_BITS-PRECISION_BITS-2];
    stage_d.sticky   = |shifted[EXT_BITS-PRECISION_BITS-3:0];
    stage_d.rnd_mode = stage_i.rnd_mode;
    stage_d.special  = stage_i.special;
  end

  // --------------------------------------------------
  // Stage 2 registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    stage_q <= stage_d;
  end

  assign valid_o = valid_q;
  assign stage_o = stage_q;

endmodule

/* rtl/mul_rounder.sv */
// Pipeline stage 3 of the multiplier, drives the block outputs
// Underflow uses tininess after rounding, as RISC-V requires
// Mode encodings 5 to 7 truncate
// Only the valid bit is reset
module mul_rounder import fp16_mul_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        valid_i,
  input  norm_stage_t stage_i,
  output logic        valid_o,
  output fp16_t       result_o,
  output status_t     status_o
);

  localparam int unsigned ABS_BITS = EXP_BITS + MAN_BITS;

  logic signed [EXP_WIDTH-1:0] exp_in;
  logic                        of_before;
  logic                        of_after;
  logic [ABS_BITS-1:0]         pre_abs;
  logic [1:0]                  round_sticky;
  logic                        round_up;
  logic [ABS_BITS-1:0]         rounded_abs;
  logic                        tiny;
  fp16_t                       regular_result;
  status_t                     regular_status;
  logic                        valid_q;
  fp16_t                       result_q;
  status_t                     status_q;

  assign exp_in = stage_i.exponent;

  // Exponent is never negative here
  assign of_before = exp_in >= EXP_WIDTH'(2**EXP_BITS - 1);

  // On overflow use the largest finite value with R and S set
  assign pre_abs = of_before ? {EXP_BITS'(2**EXP_BITS - 2), {MAN_BITS{1'b1}}}
                             : {exp_in[EXP_BITS-1:0], stage_i.mantissa[MAN_BITS:1]};
  assign round_sticky = of_before ? 2'b11
                                  : {stage_i.mantissa[0], stage_i.guard | stage_i.sticky};

  // --------------------------------------------------
  // Rounding
  // --------------------------------------------------
  always_comb begin : round_decision
    case (stage_i.rnd_mode)
      // Ties go to the even LSB
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & stage_i.sign;
      RUP:     round_up = (|round_sticky) & ~stage_i.sign;
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  // A carry out of the fraction bumps the exponent field
  assign rounded_abs = pre_abs + ABS_BITS'(round_up);
  assign of_after    = (rounded_abs[ABS_BITS-1 -: EXP_BITS] == '1);

  // Tiny after rounding; 0x3FF rounded up to the smallest normal is still tiny
  // unless rounding at one more bit of precision would also have carried
  assign tiny = (rounded_abs[ABS_BITS-1 -: EXP_BITS] == '0) ||
                ((pre_abs[ABS_BITS-1 -: EXP_BITS] == '0) &&
                 (rounded_abs[ABS_BITS-1 -: EXP_BITS] == EXP_BITS'(1)) &&
                 ((round_sticky != 2'b11) ||
                  (!stage_i.guard && ((stage_i.rnd_mode == RNE) ||
                                      (stage_i.rnd_mode == RMM)))));

  // --------------------------------------------------
  // Result and flags
  // --------------------------------------------------
  assign regular_result    = {stage_i.sign, rounded_abs};
  assign regular_status.nv = 1'b0;
  // No division in this unit
  assign regular_status.dz = 1'b0;
  assign regular_status.of = of_before | of_after;
  assign regular_status.nx = (|round_sticky) | of_before | of_after;
  assign regular_status.uf = tiny & regular_status.nx;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Special bypass wins over the regular datapath
  always_ff @(posedge clk_i) begin
    result_q <= stage_i.special.is_special ? stage_i.special.result : regular_result;
    status_q <= stage_i.special.is_special ? stage_i.special.status : regular_status;
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign status_o = status_q;

endmodule

/* rtl/fp16_mul_top.sv */
// Pipelined binary16 multiplier with RISC-V rounding and flags
// Fixed latency of three cycles, one operation per cycle
// No back-pressure; each result is shown for one cycle only
// reset_i is synchronous and clears the valid bits only
module fp16_mul_top import fp16_mul_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        valid_i,
  input  fp16_t       operand_a_i,
  input  fp16_t       operand_b_i,
  input  round_mode_e rnd_mode_i,
  output logic        valid_o,
  output fp16_t       result_o,
  output status_t     status_o
);

  fp_info_t    info_a;
  fp_info_t    info_b;
  special_t    special;
  logic        prod_valid;
  prod_stage_t prod_stage;
  logic        norm_valid;
  norm_stage_t norm_stage;

  // --------------------------------------------------
  // Input decode, combinational
  // --------------------------------------------------
  fp_classifier fp_classifier_inst (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .info_a_o    (info_a),
    .info_b_o    (info_b)
  );

  mul_special_cases mul_special_cases_inst (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .info_a_i    (info_a),
    .info_b_i    (info_b),
    .special_o   (special)
  );

  // --------------------------------------------------
  // Three register stages
  // --------------------------------------------------
  mantissa_multiplier mantissa_multiplier_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .info_a_i    (info_a),
    .info_b_i    (info_b),
    .rnd_mode_i  (rnd_mode_i),
    .special_i   (special),
    .valid_o     (prod_valid),
    .stage_o     (prod_stage)
  );

  mul_normalizer mul_normalizer_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (prod_valid),
    .stage_i (prod_stage),
    .valid_o (norm_valid),
    .stage_o (norm_stage)
  );

  mul_rounder mul_rounder_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (norm_valid),
    .stage_i  (norm_stage),
    .valid_o  (valid_o),
    .result_o (result_o),
    .status_o (status_o)
  );

endmodule

/* include/fp16_ref_model.svh */
// Exact binary16 multiply model for the testbench
// Included inside the testbench module body
// Mode follows the RISC-V frm encoding from 0 for RNE to 4 for RMM
// Returns {result, nv, dz, of, uf, nx} with tininess after rounding
`ifndef FP16_REF_MODEL_SVH
`define FP16_REF_MODEL_SVH

// Rounds mag * 2^-shift to an integer in the given mode
function automatic longint round_scaled(longint mag, int shift, logic [2:0] mode, logic sign,
                                        output logic inexact);
  longint q;
  longint rem;
  longint half;
  logic   up;
  if (shift <= 0) begin
    inexact = 1'b0;
    return mag <<< (-shift);
  end
  q       = mag >> shift;
  rem     = mag - (q << shift);
  half    = longint'(1) << (shift - 1);
  inexact = (rem != 0);
  case (mode)
    3'd0:    up = (rem > half) || ((rem == half) && q[0]);
    3'd2:    up = inexact && sign;
    3'd3:    up = inexact && !sign;
    3'd4:    up = (rem >= half);
    default: up = 1'b0;
  endcase
  return q + longint'(up);
endfunction

function automatic logic [20:0] fp16_mul_model(logic [15:0] a, logic [15:0] b,
                                               logic [2:0] mode);
  logic   sign;
  logic   nan_a;
  logic   nan_b;
  logic   snan;
  longint mag;
  longint q;
  longint q_unb;
  int     ex;
  int     msb;
  int     lsb;
  logic   nx;
  logic   nx_unb;
  logic   tiny;
  sign  = a[15] ^ b[15];
  nan_a = (a[14:10] == 5'h1f) && (a[9:0] != 0);
  nan_b = (b[14:10] == 5'h1f) && (b[9:0] != 0);
  snan  = (nan_a && !a[9]) || (nan_b && !b[9]);
  if (((a[14:0] == 15'h7c00) && (b[14:0] == 0)) || ((a[14:0] == 0) && (b[14:0] == 15'h7c00)))
    return {16'h7e00, 5'b10000};
  if (nan_a || nan_b)
    return {16'h7e00, snan, 4'b0000};
  if ((a[14:0] == 15'h7c00) || (b[14:0] == 15'h7c00))
    return {sign, 15'h7c00, 5'b00000};
  mag = {a[14:10] != 0, a[9:0]} * {b[14:10] != 0, b[9:0]};
  if (mag == 0)
    return {sign, 15'h0000, 5'b00000};
  // Value is mag * 2^ex
  ex  = ((a[14:10] == 0) ? 1 : int'(a[14:10])) + ((b[14:10] == 0) ? 1 : int'(b[14:10])) - 50;
  msb = 0;
  for (int i = 0; i < 22; i++) begin
    if (mag[i]) begin
      msb = i;
    end
  end
  lsb = (msb + ex - 10 < -24) ? -24 : msb + ex - 10;
  q   = round_scaled(mag, lsb - ex, mode, sign, nx);
  if (q == 2048) begin
    q   = 1024;
    lsb = lsb + 1;
  end
  // Same value rounded with an unbounded exponent range
  q_unb = round_scaled(mag, msb - 10, mode, sign, nx_unb);
  tiny  = (msb + ex + ((q_unb == 2048) ? 1 : 0)) < -14;
  if (lsb + 25 >= 31) begin
    if ((mode == 3'd1) || ((mode == 3'd2) && !sign) || ((mode == 3'd3) && sign))
      return {sign, 15'h7bff, 5'b00101};
    return {sign, 15'h7c00, 5'b00101};
  end
  if (q < 1024)
    return {sign, 5'd0, q[9:0], 3'b000, tiny && nx, nx};
  return {sign, 5'(lsb + 25), q[9:0], 3'b000, tiny && nx, nx};
endfunction

`endif

/* bench/tb_fp16_mul.sv */
// Random testbench for the pipelined binary16 multiplier
// Operands mix uniform words with zeros, subnormals, infinities and NaNs
// Expected values come from the exact model in fp16_ref_model.svh
// Outputs are sampled on the falling edge and inputs change on the rising edge
module tb_fp16_mul import fp16_mul_pkg::*; ();

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_OPS      = 2000;
  // Register stages between valid_i and valid_o
  localparam int LATENCY      = 3;
  // valid_i is high about 70 percent of cycles so twice the op count covers stimulus
  localparam int LIMIT_CYCLES = 2 * NUM_OPS + RESET_CYCLES + 20;

  `include "fp16_ref_model.svh"

  // One operation in flight with the cycle its result is due
  typedef struct packed {
    logic [31:0] due;
    logic [15:0] a;
    logic [15:0] b;
    logic [2:0]  mode;
    logic [20:0] expected;
  } op_entry_t;

  logic        clk_i;
  logic        reset_i;
  logic        valid_i;
  fp16_t       operand_a_i;
  fp16_t       operand_b_i;
  round_mode_e rnd_mode_i;
  logic        valid_o;
  fp16_t       result_o;
  status_t     status_o;

  integer      seed = 73128;
  logic [31:0] cycle;
  op_entry_t   expected_q[$];

  fp16_mul_top fp16_mul_top_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .rnd_mode_i  (rnd_mode_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .status_o    (status_o)
  );

  always #(PERIOD / 2) clk_i = ~clk_i;

  // Rising edges seen so far
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Half the draws come from special classes
  task automatic draw_operand(output logic [15:0] value);
    logic [31:0] pick;
    logic [31:0] bits;
    pick = $random(seed);
    bits = $random(seed);
    case (pick[3:0])
      4'd8:    value = {bits[15], 15'h0000};
      4'd9:    value = {bits[15], 5'd0, bits[9:0]};
      4'd10:   value = {bits[15], 15'h7c00};
      // Quiet NaN with the top mantissa bit set
      4'd11:   value = {bits[15], 5'h1f, 1'b1, bits[8:0]};
      // Signalling NaN that never matches the infinity pattern
      4'd12:   value = {bits[15], 5'h1f, 1'b0, bits[8:1], 1'b1};
      // Exponent 28 to 30 so products overflow
      4'd13:   value = {bits[15], 5'd28 + 5'(bits[11:10] % 3), bits[9:0]};
      // Exponent 1 to 4 so products land among subnormals
      4'd14:   value = {bits[15], 5'd1 + 5'(bits[11:10]), bits[9:0]};
      4'd15:   value = {bits[15], 5'd6 + 5'(bits[12:10]), bits[9:0]};
      default: value = bits[15:0];
    endcase
  endtask

  // --------------------------------------------------
  // Checker on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin : check_outputs
    logic      expect_valid;
    op_entry_t entry;
    if (cycle > 0) begin
      expect_valid = (expected_q.size() != 0) && (expected_q[0].due == cycle);
      check_value("valid_o timing", 32'(expect_valid), 32'(valid_o));
      if (valid_o) begin
        entry = expected_q.pop_front();
        check_value($sformatf("result a=%h b=%h rm=%0d", entry.a, entry.b, entry.mode),
                    32'(entry.expected[20:5]), 32'(result_o));
        check_value($sformatf("status a=%h b=%h rm=%0d", entry.a, entry.b, entry.mode),
                    32'(entry.expected[4:0]), 32'(status_o));
      end
      // Input seen now is sampled on the next rising edge
      if (valid_i && !reset_i) begin
        entry.due      = cycle + LATENCY;
        entry.a        = operand_a_i;
        entry.b        = operand_b_i;
        entry.mode     = rnd_mode_i;
        entry.expected = fp16_mul_model(operand_a_i, operand_b_i, rnd_mode_i);
        expected_q.push_back(entry);
      end
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : drive_stimulus
    int          issued;
    logic [15:0] a_word;
    logic [15:0] b_word;
    logic [31:0] go;
    issued      = 0;
    cycle       = '0;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    rnd_mode_i  = RNE;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    while (issued < NUM_OPS) begin
      draw_operand(a_word);
      draw_operand(b_word);
      go = $random(seed);
      // 90 of 128 is about 70 percent
      valid_i     <= (go[6:0] < 7'd90);
      operand_a_i <= a_word;
      operand_b_i <= b_word;
      rnd_mode_i  <= round_mode_e'(3'({$random(seed)} % 5));
      if (go[6:0] < 7'd90) begin
        issued = issued + 1;
      end
      @(posedge clk_i);
    end
    valid_i <= 1'b0;
    while (expected_q.size() != 0) begin
      @(posedge clk_i);
    end
    // A few idle cycles to catch stray valid_o pulses
    repeat (4) @(posedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(LIMIT_CYCLES * PERIOD);
    $display("Timeout: the run did not finish in %0d cycles", LIMIT_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* all.f */
+incdir+include
rtl/fp16_mul_pkg.sv
rtl/fp_classifier.sv
rtl/mul_special_cases.sv
rtl/mantissa_multiplier.sv
rtl/mul_normalizer.sv
rtl/mul_rounder.sv
rtl/fp16_mul_top.sv
bench/tb_fp16_mul.sv

/* Bender.yml */
package:
  name: fp16_mul

sources:
  - files:
      - rtl/fp16_mul_pkg.sv
      - rtl/fp_classifier.sv
      - rtl/mul_special_cases.sv
      - rtl/mantissa_multiplier.sv
      - rtl/mul_normalizer.sv
      - rtl/mul_rounder.sv
      - rtl/fp16_mul_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_fp16_mul.sv
